/* dv/wide_adder_pipe_checker.sv */
// Handshake checker for the adder pipe covering reset state and channel stability
`default_nettype none

module wide_adder_pipe_checker (
	input logic                clk,
	input logic                rst_n,
	input logic                req_ready,
	input logic                rsp_valid,
	input logic                rsp_ready,
	input adder_pkg::add_rsp_t rsp
);

	// Failures seen so far
	int unsigned fail_count = 0;

	// Output channel idle in reset and on the first edge after it
	rsp_idle_after_reset: assert property (
		@(posedge clk) (!rst_n || $rose(rst_n)) |-> !rsp_valid
	) else begin
		$error("rsp_valid high during or right after reset");
		fail_count++;
	end

	// Empty pipe takes a request straight away
	req_open_after_reset: assert property (
		@(posedge clk) (!rst_n || $rose(rst_n)) |-> req_ready
	) else begin
		$error("req_ready low during or right after reset");
		fail_count++;
	end

	// A stalled response keeps its valid and its payload
	rsp_hold_on_stall: assert property (
		@(posedge clk) disable iff (!rst_n)
		rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp)
	) else begin
		$error("rsp changed or dropped while stalled");
		fail_count++;
	end

endmodule

`default_nettype wire

/* dv/wide_adder_pipe_tb.sv */
// Testbench for the pipelined adder with directed and random traffic against a 33-bit model
`default_nettype none

module wide_adder_pipe_tb;

	localparam int NUM_SLICES   = 4;
	localparam int PERIOD       = 40;
	localparam int RESET_CYCLES = 10;
	localparam int MAX_STALL    = 6;
	localparam int N_DIR_ADD    = 9;
	localparam int N_DIR_SUB    = 7;
	localparam int N_BURST      = 200;
	localparam int N_STALL      = 300;
	localparam int N_FULL       = NUM_SLICES + 1;
	localparam int N_PRE_RESET  = 6;
	localparam int N_POST_RESET = 50;
	localparam int TOTAL_TXN    = N_DIR_ADD + N_DIR_SUB + N_BURST + N_STALL + N_FULL
		+ N_PRE_RESET + N_POST_RESET;
	localparam longint WATCHDOG_TIME =
		longint'(TOTAL_TXN) * (NUM_SLICES + MAX_STALL) * PERIOD * 4;
	localparam logic [31:0] SEED = 32'h1c0b_1cfc;

	logic                clk;
	logic                rst_n;
	logic                req_valid;
	logic                req_ready;
	adder_pkg::add_req_t req;
	logic                rsp_valid;
	logic                rsp_ready;
	adder_pkg::add_rsp_t rsp;

	// Scoreboard state updated on the falling edge
	adder_pkg::add_rsp_t exp_q[$];
	int                  accept_q[$];
	int                  cycle_cnt = 0;
	int                  n_checks = 0;
	int                  n_errors = 0;
	int                  n_tests = 0;
	int                  full_seen = 0;
	int                  checks_at_start = 0;
	int                  errors_at_start = 0;
	string               test_name = "reset";
	logic                check_latency = 1'b0;

	// Response side controls
	logic                stall_mode;
	logic                hold_full;
	logic [31:0]         stim_state;

	wide_adder_pipe #(
		.NUM_SLICES(NUM_SLICES)
	) wide_adder_pipe_inst (
		.clk(clk),
		.rst_n(rst_n),
		.req_valid(req_valid),
		.req_ready(req_ready),
		.req(req),
		.rsp_valid(rsp_valid),
		.rsp_ready(rsp_ready),
		.rsp(rsp)
	);

	bind wide_adder_pipe wide_adder_pipe_checker checker_inst (
		.clk(clk),
		.rst_n(rst_n),
		.req_ready(req_ready),
		.rsp_valid(rsp_valid),
		.rsp_ready(rsp_ready),
		.rsp(rsp)
	);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	// Classic 32-bit LCG constants
	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic adder_pkg::add_req_t make_req(input adder_pkg::word_t a,
		input adder_pkg::word_t b, input logic cin, input adder_pkg::add_op_e op);
		adder_pkg::add_req_t r;
		r.a   = a;
		r.b   = b;
		r.cin = cin;
		r.op  = op;
		return r;
	endfunction

	function automatic adder_pkg::add_req_t random_req();
		adder_pkg::add_req_t r;
		stim_state = lcg_next(stim_state);
		r.a        = stim_state;
		stim_state = lcg_next(stim_state);
		r.b        = stim_state;
		stim_state = lcg_next(stim_state);
		r.cin      = stim_state[31];
		r.op       = adder_pkg::add_op_e'(stim_state[30]);
		return r;
	endfunction

	// Plain 33-bit arithmetic where bit 32 of a subtract is the borrow
	function automatic adder_pkg::add_rsp_t expected_rsp(input adder_pkg::add_req_t r);
		adder_pkg::add_rsp_t e;
		logic [32:0]         full;
		if (r.op == adder_pkg::OP_SUB) begin
			full   = {1'b0, r.a} - {1'b0, r.b};
			e.sum  = full[31:0];
			e.cout = ~full[32];
			e.ovf  = (r.a[31] != r.b[31]) && (e.sum[31] != r.a[31]);
		end else begin
			full   = {1'b0, r.a} + {1'b0, r.b} + {32'd0, r.cin};
			e.sum  = full[31:0];
			e.cout = full[32];
			e.ovf  = (r.a[31] == r.b[31]) && (e.sum[31] != r.a[31]);
		end
		return e;
	endfunction

	// Present one request and return on the edge that takes it
	task automatic send_req(input adder_pkg::add_req_t r);
		req       <= r;
		req_valid <= 1'b1;
		do begin
			@(negedge clk);
		end while (!req_ready);
		@(posedge clk);
	endtask

	task automatic idle_cycles(input int n);
		req_valid <= 1'b0;
		repeat (n) @(posedge clk);
	endtask

	task automatic wait_drain();
		req_valid <= 1'b0;
		while (exp_q.size() != 0) @(posedge clk);
	endtask

	task automatic start_test(input string name, input logic latency);
		test_name       = name;
		check_latency   = latency;
		checks_at_start = n_checks;
		errors_at_start = n_errors;
	endtask

	task automatic end_test();
		wait_drain();
		n_tests++;
		$display("%s: %0d responses checked, %0d errors", test_name,
			n_checks - checks_at_start, n_errors - errors_at_start);
	endtask

	always @(negedge clk) begin
		adder_pkg::add_rsp_t exp_rsp;
		int                  lat;
		if (rst_n === 1'b1) begin
			cycle_cnt++;
			if (req_valid && req_ready) begin
				exp_q.push_back(expected_rsp(req));
				accept_q.push_back(cycle_cnt);
			end
			if (req_valid && !req_ready) begin
				full_seen++;
			end
			if (rsp_valid && rsp_ready) begin
				n_checks++;
				assert (exp_q.size() != 0) else begin
					n_errors++;
					$display("ERROR: %s got a response with no request outstanding", test_name);
				end
				if (exp_q.size() != 0) begin
					exp_rsp = exp_q.pop_front();
					lat     = cycle_cnt - accept_q.pop_front();
					assert (rsp == exp_rsp) else begin
						n_errors++;
						$display("CHECK FAILED %s expected sum=%h cout=%b ovf=%b actual sum=%h cout=%b ovf=%b",
							test_name, exp_rsp.sum, exp_rsp.cout, exp_rsp.ovf,
							rsp.sum, rsp.cout, rsp.ovf);
					end
					if (check_latency) begin
						assert (lat == NUM_SLICES) else begin
							n_errors++;
							$display("CHECK FAILED %s latency expected %0d actual %0d",
								test_name, NUM_SLICES, lat);
						end
					end
				end
			end
		end
	end

	// Consumer side with random stalls of at most MAX_STALL cycles
	initial begin : ready_driver
		int          stall_len;
		logic [31:0] stall_state;
		stall_len   = 0;
		stall_state = ~SEED;
		rsp_ready <= 1'b1;
		forever begin
			@(posedge clk);
			stall_state = lcg_next(stall_state);
			if (hold_full) begin
				rsp_ready <= 1'b0;
			end else if (!stall_mode || stall_len >= MAX_STALL) begin
				rsp_ready <= 1'b1;
				stall_len = 0;
			end else if (stall_state[31:29] < 3'd3) begin
				rsp_ready <= 1'b0;
				stall_len++;
			end else begin
				rsp_ready <= 1'b1;
				stall_len = 0;
			end
		end
	end

	initial begin : watchdog
		#(WATCHDOG_TIME);
		$display("ERROR: watchdog expired after %0d time units, %0d responses never arrived",
			WATCHDOG_TIME, exp_q.size());
		$display("TESTBENCH FAILED");
		$finish;
	end

	initial begin : main_sequence
		int i;
		int gap;
		int total_errors;
		req_valid  <= 1'b0;
		req        <= '0;
		rst_n      <= 1'b0;
		stall_mode <= 1'b0;
		hold_full  <= 1'b0;
		stim_state = SEED;
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;
		repeat (2) @(posedge clk);

		// Carry chains through every byte boundary
		start_test("directed_add", 1'b1);
		send_req(make_req(32'hffff_ffff, 32'h0000_0001, 1'b0, adder_pkg::OP_ADD));
		send_req(make_req(32'hffff_ffff, 32'h0000_0000, 1'b1, adder_pkg::OP_ADD));
		send_req(make_req(32'h0000_00ff, 32'h0000_0001, 1'b0, adder_pkg::OP_ADD));
		send_req(make_req(32'h0000_ffff, 32'h0000_0001, 1'b0, adder_pkg::OP_ADD));
		send_req(make_req(32'h00ff_ffff, 32'h0000_0001, 1'b0, adder_pkg::OP_ADD));
		send_req(make_req(32'h00ff_00ff, 32'h0001_0001, 1'b1, adder_pkg::OP_ADD));
		send_req(make_req(32'h7fff_ffff, 32'h0000_0001, 1'b0, adder_pkg::OP_ADD));
		send_req(make_req(32'h8000_0000, 32'h8000_0000, 1'b0, adder_pkg::OP_ADD));
		send_req(make_req(32'hffff_ffff, 32'hffff_ffff, 1'b1, adder_pkg::OP_ADD));
		end_test();

		// Borrows and signed overflow plus one subtract that carries an unused cin
		start_test("directed_sub", 1'b1);
		send_req(make_req(32'h0000_0000, 32'h0000_0001, 1'b0, adder_pkg::OP_SUB));
		send_req(make_req(32'h8000_0000, 32'h0000_0001, 1'b0, adder_pkg::OP_SUB));
		send_req(make_req(32'h7fff_ffff, 32'hffff_ffff, 1'b0, adder_pkg::OP_SUB));
		send_req(make_req(32'h0000_0005, 32'h0000_0005, 1'b0, adder_pkg::OP_SUB));
		send_req(make_req(32'h0000_0001, 32'h0000_0002, 1'b0, adder_pkg::OP_SUB));
		send_req(make_req(32'h0000_0000, 32'h0000_0000, 1'b1, adder_pkg::OP_SUB));
		send_req(make_req(32'h8000_0000, 32'h8000_0000, 1'b0, adder_pkg::OP_SUB));
		end_test();

		// One request per cycle, so req_ready never drops
		start_test("burst_random", 1'b1);
		full_seen = 0;
		for (i = 0; i < N_BURST; i++) begin
			send_req(random_req());
		end
		assert (full_seen == 0) else begin
			n_errors++;
			$display("ERROR: %s req_ready dropped %0d times with the output never stalled",
				test_name, full_seen);
		end
		end_test();

		start_test("stall_and_gaps", 1'b0);
		stall_mode <= 1'b1;
		for (i = 0; i < N_STALL; i++) begin
			send_req(random_req());
			stim_state = lcg_next(stim_state);
			gap = stim_state[31] ? 0 : int'(stim_state[30:27]) % (MAX_STALL + 1);
			idle_cycles(gap);
		end
		stall_mode <= 1'b0;
		wait_drain();
		// Fill all stages with the output blocked and then offer one more
		full_seen = 0;
		hold_full <= 1'b1;
		for (i = 0; i < NUM_SLICES; i++) begin
			send_req(random_req());
		end
		req       <= random_req();
		req_valid <= 1'b1;
		repeat (NUM_SLICES) @(posedge clk);
		hold_full <= 1'b0;
		send_req(req);
		assert (full_seen > 0) else begin
			n_errors++;
			$display("ERROR: %s req_ready never dropped with the pipe full", test_name);
		end
		end_test();

		start_test("reset_midstream", 1'b1);
		for (i = 0; i < N_PRE_RESET; i++) begin
			send_req(random_req());
		end
		rst_n     <= 1'b0;
		req_valid <= 1'b0;
		// Items in flight are dropped by the reset
		exp_q.delete();
		accept_q.delete();
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;
		repeat (2) @(posedge clk);
		for (i = 0; i < N_POST_RESET; i++) begin
			send_req(random_req());
		end
		end_test();

		repeat (4) @(posedge clk);
		total_errors = n_errors + int'(wide_adder_pipe_inst.checker_inst.fail_count);
		$display("%0d tests, %0d responses checked, %0d errors, %0d assertion failures",
			n_tests, n_checks, n_errors, wide_adder_pipe_inst.checker_inst.fail_count);
		if (total_errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* hdl/adder_pkg.sv */
// Adder package with the shared widths, request and response records and op codes
`default_nettype none

package adder_pkg;

	// Width of one slice handled per pipeline stage
	localparam int SLICE_W = 8;

	// Full operand width
	localparam int WORD_W = 32;

	typedef logic [SLICE_W-1:0] slice_t;
	typedef logic [WORD_W-1:0] word_t;

	// Subtract is a + ~b + 1, so cout high means no borrow
	typedef enum logic {
		OP_ADD = 1'b0,
		OP_SUB = 1'b1
	} add_op_e;

	// Request as it arrives on the input channel
	typedef struct packed {
		word_t   a;
		word_t   b;
		logic    cin;
		add_op_e op;
	} add_req_t;

	// Response on the output channel
	typedef struct packed {
		word_t sum;
		logic  cout;
		logic  ovf;
	} add_rsp_t;

	// Record passed from stage to stage, b already inverted for subtract
	typedef struct packed {
		word_t a;
		word_t b;
		word_t sum;
		logic  carry;
	} stage_t;

endpackage

`default_nettype wire

/* hdl/adder_slice_stage.sv */
// Slice stage, adds one byte of the word and registers the record with valid/ready
`default_nettype none

module adder_slice_stage #(
	parameter int SLICE_IDX  = 0,
	parameter int NUM_SLICES = 4
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              in_valid,
	output logic              in_ready,
	input  adder_pkg::stage_t in_stage,
	output logic              out_valid,
	input  logic              out_ready,
	output adder_pkg::stage_t out_stage,
	output logic              out_msb_carry
);

	localparam int LSB = SLICE_IDX * adder_pkg::SLICE_W;
	localparam bit LAST = (SLICE_IDX == NUM_SLICES - 1);

	adder_pkg::slice_t a_byte;
	adder_pkg::slice_t b_byte;
	adder_pkg::slice_t sum_byte;
	logic              slice_cout;
	logic              slice_c7;
	adder_pkg::stage_t next_stage;
	adder_pkg::stage_t stage_q;
	logic              valid_q;
	logic              msb_carry_q;
	logic              load;

	// Byte of this stage
	assign a_byte = in_stage.a[LSB +: adder_pkg::SLICE_W];
	assign b_byte = in_stage.b[LSB +: adder_pkg::SLICE_W];

	ling_adder8 adder_inst (
		.a(a_byte),
		.b(b_byte),
		.cin(in_stage.carry),
		.sum(sum_byte),
		.cout(slice_cout),
		.c7(slice_c7)
	);

	always_comb begin
		next_stage = in_stage;
		next_stage.sum[LSB +: adder_pkg::SLICE_W] = sum_byte;
		next_stage.carry = slice_cout;
		// Operand bits nobody downstream reads
		if (LAST) begin
			next_stage.a = '0;
			next_stage.b = '0;
		end else begin
			next_stage.a[LSB +: adder_pkg::SLICE_W] = '0;
			next_stage.b[LSB +: adder_pkg::SLICE_W] = '0;
		end
	end

	// Empty register or item leaving this cycle
	assign in_ready = !valid_q || out_ready;
	assign load = in_valid && in_ready;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_q <= 1'b0;
		end else if (in_ready) begin
			valid_q <= in_valid;
		end
	end

	// Payload only moves on a transfer, so it holds under back-pressure
	always_ff @(posedge clk) begin
		if (load) begin
			stage_q     <= next_stage;
			msb_carry_q <= slice_c7;
		end
	end

	assign out_valid     = valid_q;
	assign out_stage     = stage_q;
	assign out_msb_carry = msb_carry_q;

endmodule

`default_nettype wire

/* hdl/ling_adder8.sv */
// Ling adder, 8-bit sum and carry out through a Knowles prefix tree
`default_nettype none

module ling_adder8 (
	input  adder_pkg::slice_t a,
	input  adder_pkg::slice_t b,
	input  logic              cin,
	output adder_pkg::slice_t sum,
	output logic              cout,
	output logic              c7
);

	logic [8:0] p;
	logic [8:0] g;
	logic [7:0] h;
	logic [7:0] c;

	// Pre-computation, carry in enters as generate of position 0
	assign p = {a | b, 1'b1};
	assign g = {a & b, cin};

	ling_prefix_tree prefix_tree_inst (
		.p(p),
		.g(g),
		.h(h),
		.c(c)
	);

	// Sum bit is the carry itself when the bit generates, else p XOR carry
	assign sum = (p[8:1] ^ h) | (g[8:1] & c);

	// Carry out from the top pseudo-carry
	assign cout = p[8] & h[7];

	// Needed upstream for the signed overflow flag
	assign c7 = c[7];

endmodule

`default_nettype wire

/* hdl/ling_prefix_tree.sv */
// Ling prefix tree, 8-bit Knowles network giving pseudo-carries and real carries
`default_nettype none

module ling_prefix_tree (
	input  logic [8:0] p,
	input  logic [8:0] g,
	output logic [7:0] h,
	output logic [7:0] c
);

	// Position 0 is the carry in, position k is operand bit k-1

	// Level 1, reduced cells over adjacent generates
	logic h_1_0;
	logic h_2_1;
	logic h_3_2;
	logic h_4_3;
	logic h_5_4;
	logic h_6_5;
	logic h_7_6;
	logic i_2_1;
	logic i_3_2;
	logic i_4_3;
	logic i_5_4;
	logic i_6_5;
	logic i_7_6;

	// Level 2, spans of 2
	logic h_2_0;
	logic h_3_0;
	logic h_4_1;
	logic h_5_2;
	logic h_6_3;
	logic h_7_4;
	logic i_4_1;
	logic i_5_2;
	logic i_6_3;
	logic i_7_4;

	// Level 3, spans of 4
	logic h_4_0;
	logic h_5_0;
	logic h_6_0;
	logic h_7_0;

	// Reduced grey cell
	assign h_1_0 = g[1] | g[0];

	// Reduced black cells
	assign h_2_1 = g[2] | g[1];
	assign i_2_1 = p[1] & p[0];
	assign h_3_2 = g[3] | g[2];
	assign i_3_2 = p[2] & p[1];
	assign h_4_3 = g[4] | g[3];
	assign i_4_3 = p[3] & p[2];
	assign h_5_4 = g[5] | g[4];
	assign i_5_4 = p[4] & p[3];
	assign h_6_5 = g[6] | g[5];
	assign i_6_5 = p[5] & p[4];
	assign h_7_6 = g[7] | g[6];
	assign i_7_6 = p[6] & p[5];

	// Grey cells reaching position 0
	assign h_2_0 = h_2_1 | (i_2_1 & g[0]);
	assign h_3_0 = h_3_2 | (i_3_2 & h_1_0);

	// Black cells
	assign h_4_1 = h_4_3 | (i_4_3 & h_2_1);
	assign i_4_1 = i_4_3 & i_2_1;
	assign h_5_2 = h_5_4 | (i_5_4 & h_3_2);
	assign i_5_2 = i_5_4 & i_3_2;
	assign h_6_3 = h_6_5 | (i_6_5 & h_4_3);
	assign i_6_3 = i_6_5 & i_4_3;
	assign h_7_4 = h_7_6 | (i_7_6 & h_5_4);
	assign i_7_4 = i_7_6 & i_5_4;

	// Overlap with h_1_0 at position 1 is harmless for an OR
	assign h_4_0 = h_4_1 | (i_4_1 & h_1_0);
	assign h_5_0 = h_5_2 | (i_5_2 & h_1_0);
	assign h_6_0 = h_6_3 | (i_6_3 & h_3_0);
	assign h_7_0 = h_7_4 | (i_7_4 & h_3_0);

	// Real carry into a bit is p of the bit below ANDed with its pseudo-carry
	assign c[0] = g[0];
	assign c[1] = p[1] & h_1_0;
	assign c[2] = p[2] & h_2_0;
	assign c[3] = p[3] & h_3_0;
	assign c[4] = p[4] & h_4_0;
	assign c[5] = p[5] & h_5_0;
	assign c[6] = p[6] & h_6_0;
	assign c[7] = p[7] & h_7_0;

	// Pseudo-carry per operand bit
	assign h[0] = h_1_0;
	assign h[1] = h_2_0;
	assign h[2] = h_3_0;
	assign h[3] = h_4_0;
	assign h[4] = h_5_0;
	assign h[5] = h_6_0;
	assign h[6] = h_7_0;

	// Top pseudo-carry folds in the last generate
	assign h[7] = g[8] | c[7];

endmodule

`default_nettype wire

/* hdl/wide_adder_pipe.sv */
// Pipelined 32-bit adder/subtractor, one byte slice per stage between two valid/ready channels
`default_nettype none

module wide_adder_pipe #(
	parameter int NUM_SLICES = 4
) (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                req_valid,
	output logic                req_ready,
	input  adder_pkg::add_req_t req,
	output logic                rsp_valid,
	input  logic                rsp_ready,
	output adder_pkg::add_rsp_t rsp
);

	adder_pkg::stage_t     head_stage;
	adder_pkg::stage_t     tail_stage;
	adder_pkg::stage_t     link_stage [NUM_SLICES+1];
	logic [NUM_SLICES:0]   link_valid;
	logic [NUM_SLICES:0]   link_ready;
	logic [NUM_SLICES-1:0] msb_carry;
	logic                  sub_op;

	assign sub_op = (req.op == adder_pkg::OP_SUB);

	// Subtract becomes a + ~b + 1, request cin only counts for add
	always_comb begin
		head_stage.a     = req.a;
		head_stage.b     = sub_op ? ~req.b : req.b;
		head_stage.sum   = '0;
		head_stage.carry = sub_op ? 1'b1 : req.cin;
	end

	// Input channel into stage 0
	assign link_stage[0] = head_stage;
	assign link_valid[0] = req_valid;
	assign req_ready     = link_ready[0];

	for (genvar k = 0; k < NUM_SLICES; k++) begin : g_slice
		adder_slice_stage #(
			.SLICE_IDX(k),
			.NUM_SLICES(NUM_SLICES)
		) stage_inst (
			.clk(clk),
			.rst_n(rst_n),
			.in_valid(link_valid[k]),
			.in_ready(link_ready[k]),
			.in_stage(link_stage[k]),
			.out_valid(link_valid[k+1]),
			.out_ready(link_ready[k+1]),
			.out_stage(link_stage[k+1]),
			.out_msb_carry(msb_carry[k])
		);
	end

	// Last stage drives the output channel
	assign tail_stage             = link_stage[NUM_SLICES];
	assign link_ready[NUM_SLICES] = rsp_ready;
	assign rsp_valid              = link_valid[NUM_SLICES];

	// Signed overflow when carry into the sign bit differs from carry out
	always_comb begin
		rsp.sum  = tail_stage.sum;
		rsp.cout = tail_stage.carry;
		rsp.ovf  = tail_stage.carry ^ msb_carry[NUM_SLICES-1];
	end

endmodule

`default_nettype wire

/* sim.f */
hdl/adder_pkg.sv
hdl/ling_prefix_tree.sv
hdl/ling_adder8.sv
hdl/adder_slice_stage.sv
hdl/wide_adder_pipe.sv
dv/wide_adder_pipe_checker.sv
dv/wide_adder_pipe_tb.sv
